//--- files.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/byte_ram.sv
verilog/mem_cfg_regs.sv
verilog/mem_ctrl.sv
verilog/mem_subsys.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module mem_subsys_tb -o mem_subsys_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mem_subsys_tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0

//--- tests/mem_subsys_chk.sv
`timescale 1ns/1ps

module mem_ctrl_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 enable,
    input logic                 fetch_ok,
    input logic                 ls_ok,
    input logic                 ram_wr,
    input mem_pkg::ctrl_state_e state
);

    a_ok_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(fetch_ok && ls_ok)) else $error("fetch_ok and ls_ok high together");

    a_fetch_ok_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_ok |=> !fetch_ok) else $error("fetch_ok longer than one cycle");

    a_ls_ok_pulse: assert property (@(posedge clk) disable iff (rst)
        ls_ok |=> !ls_ok) else $error("ls_ok longer than one cycle");

    // writes only happen inside a store
    a_no_wr_outside_store: assert property (@(posedge clk) disable iff (rst)
        (state != mem_pkg::ST_STORE) |-> !ram_wr)
        else $error("ram write outside a store");

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |=> (!fetch_ok && !ls_ok)) else $error("ok pulse right after reset");

endmodule

bind mem_ctrl mem_ctrl_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .fetch_ok (fetch_ok),
    .ls_ok    (ls_ok),
    .ram_wr   (ram_wr),
    .state    (state)
);

//--- tests/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsys_tb;

    localparam int N_REQ = 60;
    localparam int BASE = 'h100;
    localparam int REGION = 64;

    logic clk, rst, psel, penable, pwrite, pready, pslverr;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;
    logic fetch_req, fetch_drop, fetch_ok, ls_req, ls_ok;
    mem_pkg::addr_t fetch_pc, ls_addr;
    mem_pkg::word_t fetch_inst, ls_wdata, ls_rdata;
    mem_pkg::mem_op_e ls_op;
    mem_pkg::mem_size_e ls_size;

    logic [7:0] ref_mem [0:`MEM_RAM_DEPTH-1];
    mem_pkg::word_t f_exp_q[$];
    mem_pkg::word_t ls_exp_q[$];
    bit ls_store_q[$];
    mem_pkg::cnt_t n_fetch, n_load, n_store;
    int seed = 32'he0dd;
    int errors, test_err0, tests_passed, tests_failed, ok_seq, ls_last_seq, f_last_seq;
    string cur_test;

    mem_subsys UUT (.*);

    always #50 clk = ~clk;

    // little-endian assembly, zero above the access size
    function automatic mem_pkg::word_t ref_read(mem_pkg::addr_t a, mem_pkg::mem_size_e sz);
        mem_pkg::word_t w;
        w = '0;
        for (int i = 0; i < int'(sz); i++) w[8*i +: 8] = ref_mem[a + mem_pkg::addr_t'(i)];
        return w;
    endfunction

    task automatic check_word(string name, mem_pkg::word_t exp, mem_pkg::word_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cnt(string name, mem_pkg::cnt_t exp, mem_pkg::cnt_t act);
        if (exp !== act) begin
            $display("FAIL %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // compare process, one entry per ok pulse
    always @(negedge clk) begin
        if (!rst && fetch_ok) begin
            ok_seq++;
            f_last_seq = ok_seq;
            if (f_exp_q.size() == 0) begin
                $display("%s: fetch_ok with no fetch outstanding", cur_test);
                errors++;
            end else begin
                check_word({cur_test, "/fetch"}, f_exp_q.pop_front(), fetch_inst);
                n_fetch++;
            end
        end
        if (!rst && ls_ok) begin
            ok_seq++;
            ls_last_seq = ok_seq;
            if (ls_exp_q.size() == 0) begin
                $display("%s: ls_ok with no request outstanding", cur_test);
                errors++;
            end else if (ls_store_q.pop_front()) begin
                void'(ls_exp_q.pop_front());
                n_store++;
            end else begin
                check_word({cur_test, "/load"}, ls_exp_q.pop_front(), ls_rdata);
                n_load++;
            end
        end
    end

    task automatic start_test(string name);
        cur_test = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("PASS %s", cur_test);
            tests_passed++;
        end else begin
            $display("FAIL %s: %0d errors", cur_test, errors - test_err0);
            tests_failed++;
        end
    endtask

    task automatic wait_done();
        while (f_exp_q.size() != 0 || ls_exp_q.size() != 0) @(negedge clk);
    endtask

    function automatic mem_pkg::mem_size_e pick_size(int r);
        case (r)
            0: return mem_pkg::SIZE_BYTE;
            1: return mem_pkg::SIZE_HALF;
            default: return mem_pkg::SIZE_WORD;
        endcase
    endfunction

    // call on a falling edge; leaves ls_req raised for one cycle
    task automatic put_ls(mem_pkg::mem_op_e op, mem_pkg::addr_t a,
                          mem_pkg::mem_size_e sz, mem_pkg::word_t d);
        ls_req = 1;
        ls_op = op;
        ls_addr = a;
        ls_size = sz;
        ls_wdata = d;
        if (op == mem_pkg::OP_WRITE) begin
            for (int i = 0; i < int'(sz); i++) ref_mem[a + mem_pkg::addr_t'(i)] = d[8*i +: 8];
            ls_exp_q.push_back('0);
            ls_store_q.push_back(1);
        end else begin
            ls_exp_q.push_back(ref_read(a, sz));
            ls_store_q.push_back(0);
        end
    endtask

    task automatic do_ls(mem_pkg::mem_op_e op, mem_pkg::addr_t a,
                         mem_pkg::mem_size_e sz, mem_pkg::word_t d);
        @(negedge clk);
        put_ls(op, a, sz, d);
        @(negedge clk);
        ls_req = 0;
        wait_done();
    endtask

    task automatic do_fetch(mem_pkg::addr_t pc);
        @(negedge clk);
        fetch_req = 1;
        fetch_pc = pc;
        f_exp_q.push_back(ref_read(pc, mem_pkg::SIZE_WORD));
        @(negedge clk);
        fetch_req = 0;
        wait_done();
    endtask

    task automatic apb_write(logic [7:0] a, logic [31:0] d);
        @(negedge clk);
        psel = 1;
        pwrite = 1;
        paddr = a;
        pwdata = d;
        @(negedge clk);
        penable = 1;
        @(negedge clk);
        psel = 0;
        penable = 0;
    endtask

    task automatic apb_read(logic [7:0] a, output logic [31:0] d, output logic err);
        @(negedge clk);
        psel = 1;
        pwrite = 0;
        paddr = a;
        @(negedge clk);
        penable = 1;
        #1;
        d = prdata;
        err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(negedge clk);
        psel = 0;
        penable = 0;
    endtask

    initial begin
        #((N_REQ * 20 + 500) * 100);
        $display("timeout: the tests did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        mem_pkg::addr_t a;
        mem_pkg::mem_size_e sz;
        logic [31:0] rd;
        logic err;
        int lat;
        clk = 0;
        rst = 1;
        n_fetch = '0;
        n_load = '0;
        n_store = '0;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {fetch_req, fetch_drop, ls_req} = '0;
        fetch_pc = '0;
        ls_addr = '0;
        ls_wdata = '0;
        ls_op = mem_pkg::OP_READ;
        ls_size = mem_pkg::SIZE_WORD;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 0;

        start_test("store_load");
        for (int i = 0; i < REGION; i += 4)
            do_ls(mem_pkg::OP_WRITE, mem_pkg::addr_t'(BASE + i), mem_pkg::SIZE_WORD, $random(seed));
        for (int i = 0; i < 32; i++) begin
            a = mem_pkg::addr_t'(BASE + $unsigned($random(seed)) % (REGION - 3));
            sz = pick_size($unsigned($random(seed)) % 3);
            do_ls((i % 2) ? mem_pkg::OP_READ : mem_pkg::OP_WRITE, a, sz, $random(seed));
        end
        end_test();

        start_test("fetch");
        @(negedge clk);
        fetch_req = 1;
        fetch_pc = mem_pkg::addr_t'(BASE);
        f_exp_q.push_back(ref_read(fetch_pc, mem_pkg::SIZE_WORD));
        // accept edge
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        fetch_req = 0;
        while (!fetch_ok && lat < 20) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
        end
        check_cnt("fetch_latency", 5, mem_pkg::cnt_t'(lat));
        for (int i = 1; i < 6; i++) do_fetch(mem_pkg::addr_t'(BASE + 4 * i + (i == 5)));
        end_test();

        start_test("arbitration");
        @(negedge clk);
        fetch_req = 1;
        fetch_pc = mem_pkg::addr_t'(BASE + 8);
        f_exp_q.push_back(ref_read(fetch_pc, mem_pkg::SIZE_WORD));
        put_ls(mem_pkg::OP_READ, mem_pkg::addr_t'(BASE + 20), mem_pkg::SIZE_WORD, '0);
        @(negedge clk);
        fetch_req = 0;
        ls_req = 0;
        wait_done();
        check_flag("arb_order", 1'b1, ls_last_seq < f_last_seq);
        end_test();

        start_test("drop");
        @(negedge clk);
        fetch_req = 1;
        fetch_pc = mem_pkg::addr_t'(BASE + 12);
        @(negedge clk);
        fetch_req = 0;
        put_ls(mem_pkg::OP_WRITE, mem_pkg::addr_t'(BASE + 32), mem_pkg::SIZE_WORD, $random(seed));
        @(negedge clk);
        ls_req = 0;
        fetch_drop = 1;
        @(negedge clk);
        fetch_drop = 0;
        wait_done();
        repeat (10) @(negedge clk);
        do_ls(mem_pkg::OP_READ, mem_pkg::addr_t'(BASE + 32), mem_pkg::SIZE_WORD, '0);
        end_test();

        start_test("enable");
        @(negedge clk);
        put_ls(mem_pkg::OP_READ, mem_pkg::addr_t'(BASE + 40), mem_pkg::SIZE_WORD, '0);
        @(negedge clk);
        ls_req = 0;
        // freeze partway through the load
        apb_write(`MEM_REG_CTRL, 32'd0);
        repeat (20) @(negedge clk);
        check_flag("load_held", 1'b1, ls_exp_q.size() == 1);
        apb_write(`MEM_REG_CTRL, 32'd1);
        wait_done();
        end_test();

        start_test("counters");
        apb_read(`MEM_REG_FETCH_CNT, rd, err);
        check_cnt("fetch_cnt", n_fetch, rd[15:0]);
        apb_read(`MEM_REG_LOAD_CNT, rd, err);
        check_cnt("load_cnt", n_load, rd[15:0]);
        apb_read(`MEM_REG_STORE_CNT, rd, err);
        check_cnt("store_cnt", n_store, rd[15:0]);
        apb_write(`MEM_REG_CTRL, 32'd3);
        apb_read(`MEM_REG_CTRL, rd, err);
        check_word("ctrl_after_clear", 32'd1, rd);
        for (int r = 1; r < 4; r++) begin
            apb_read(8'(4 * r), rd, err);
            check_cnt("cnt_cleared", '0, rd[15:0]);
        end
        apb_read(8'h10, rd, err);
        check_flag("unmapped_err", 1'b1, err);
        check_word("unmapped_data", 32'd0, rd);
        end_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/byte_ram.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module byte_ram (
    input  logic                   clk,
    input  mem_pkg::addr_t         addr,
    input  logic                   wr,
    input  logic [`MEM_BYTE_W-1:0] wdata,
    output logic [`MEM_BYTE_W-1:0] rdata
);

    logic [`MEM_BYTE_W-1:0] mem [0:`MEM_RAM_DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- verilog/mem_cfg_regs.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_cfg_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        fetch_ok,
    input  logic        ls_ok,
    input  logic        ls_was_store,
    output logic        enable
);

    logic          acc;
    logic          wr_acc;
    logic          mapped;
    logic          cnt_clr;
    mem_pkg::cnt_t fetch_cnt;
    mem_pkg::cnt_t load_cnt;
    mem_pkg::cnt_t store_cnt;

    // saturating count, clear wins over an event
    function automatic mem_pkg::cnt_t bump(input mem_pkg::cnt_t cur,
                                           input logic clr,
                                           input logic ev);
        mem_pkg::cnt_t nxt;
        nxt = cur;
        if (clr) begin
            nxt = '0;
        end else if (ev && cur != '1) begin
            nxt = cur + 1'b1;
        end
        return nxt;
    endfunction

    assign acc     = psel && penable;
    assign wr_acc  = acc && pwrite;
    assign cnt_clr = wr_acc && paddr == `MEM_REG_CTRL && pwdata[1];
    assign mapped  = paddr == `MEM_REG_CTRL || paddr == `MEM_REG_FETCH_CNT
                     || paddr == `MEM_REG_LOAD_CNT || paddr == `MEM_REG_STORE_CNT;
    assign pready  = 1'b1;
    assign pslverr = acc && !mapped;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b1;
            fetch_cnt <= '0;
            load_cnt  <= '0;
            store_cnt <= '0;
        end else begin
            if (wr_acc && paddr == `MEM_REG_CTRL) begin
                enable <= pwdata[0];
            end
            fetch_cnt <= bump(fetch_cnt, cnt_clr, fetch_ok);
            load_cnt  <= bump(load_cnt, cnt_clr, ls_ok && !ls_was_store);
            store_cnt <= bump(store_cnt, cnt_clr, ls_ok && ls_was_store);
        end
    end

    // clear bit reads back as zero
    always_comb begin
        case (paddr)
            `MEM_REG_CTRL:      prdata = {31'd0, enable};
            `MEM_REG_FETCH_CNT: prdata = 32'(fetch_cnt);
            `MEM_REG_LOAD_CNT:  prdata = 32'(load_cnt);
            `MEM_REG_STORE_CNT: prdata = 32'(store_cnt);
            default:            prdata = 32'd0;
        endcase
    end

endmodule

//--- verilog/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// byte address space, 128 KiB
`define MEM_ADDR_W 17
`define MEM_RAM_DEPTH (1 << `MEM_ADDR_W)

// datapath widths
`define MEM_WORD_W 32
`define MEM_BYTE_W 8

// apb register offsets
`define MEM_REG_CTRL      8'h00
`define MEM_REG_FETCH_CNT 8'h04
`define MEM_REG_LOAD_CNT  8'h08
`define MEM_REG_STORE_CNT 8'h0C

// completion counters
`define MEM_CNT_W 16

`endif

//--- verilog/mem_ctrl.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   fetch_req,
    input  logic                   fetch_drop,
    input  mem_pkg::addr_t         fetch_pc,
    output logic                   fetch_ok,
    output mem_pkg::word_t         fetch_inst,
    input  logic                   ls_req,
    input  mem_pkg::mem_op_e       ls_op,
    input  mem_pkg::mem_size_e     ls_size,
    input  mem_pkg::addr_t         ls_addr,
    input  mem_pkg::word_t         ls_wdata,
    output logic                   ls_ok,
    output logic                   ls_was_store,
    output mem_pkg::word_t         ls_rdata,
    output mem_pkg::addr_t         ram_addr,
    output logic                   ram_wr,
    output logic [`MEM_BYTE_W-1:0] ram_wdata,
    input  logic [`MEM_BYTE_W-1:0] ram_rdata
);

    // running request
    mem_pkg::ctrl_state_e state;
    mem_pkg::ctrl_state_e eff_state;
    logic [2:0]           cnt;
    logic [2:0]           run_len;
    mem_pkg::addr_t       run_addr;
    mem_pkg::word_t       run_data;
    mem_pkg::word_t       rd_data;
    logic                 ram_wr_q;
    mem_pkg::addr_t       ram_addr_q;

    // one buffered request per port
    logic                 fb_valid;
    mem_pkg::addr_t       fb_pc;
    logic                 lsb_valid;
    mem_pkg::mem_op_e     lsb_op;
    mem_pkg::mem_size_e   lsb_size;
    mem_pkg::addr_t       lsb_addr;
    mem_pkg::word_t       lsb_wdata;

    logic                 drop_run;
    logic                 drop_lsb;
    logic                 fb_live;
    logic                 lsb_live;
    logic                 ls_pend;
    logic                 f_pend;
    logic                 idle;
    logic                 start_ls;
    logic                 start_f;
    logic                 cap_ls;
    logic                 cap_f;
    logic                 step_rd;
    logic                 step_st;
    logic                 at_end;

    mem_pkg::mem_op_e     sel_op;
    mem_pkg::mem_size_e   sel_size;
    mem_pkg::addr_t       sel_addr;
    mem_pkg::word_t       sel_wdata;
    mem_pkg::addr_t       start_addr;

    always_comb begin
        // drop kills running reads and buffered reads, never stores
        drop_run = fetch_drop
                   && (state == mem_pkg::ST_FETCH || state == mem_pkg::ST_LOAD);
        drop_lsb = fetch_drop && lsb_valid && lsb_op == mem_pkg::OP_READ;
        eff_state = drop_run ? mem_pkg::ST_IDLE : state;

        fb_live  = fb_valid && !fetch_drop;
        lsb_live = lsb_valid && !drop_lsb;
        ls_pend  = ls_req || lsb_live;
        f_pend   = fetch_req || fb_live;
        idle     = eff_state == mem_pkg::ST_IDLE;

        // load/store side has priority
        start_ls = enable && idle && ls_pend;
        start_f  = enable && idle && !ls_pend && f_pend;
        cap_ls   = enable && ls_req && !start_ls;
        cap_f    = enable && fetch_req && !start_f;

        step_rd = enable
                  && (eff_state == mem_pkg::ST_FETCH || eff_state == mem_pkg::ST_LOAD);
        step_st = enable && eff_state == mem_pkg::ST_STORE;
        at_end  = cnt == run_len;

        sel_op    = ls_req ? ls_op : lsb_op;
        sel_size  = ls_req ? ls_size : lsb_size;
        sel_addr  = ls_req ? ls_addr : lsb_addr;
        sel_wdata = ls_req ? ls_wdata : lsb_wdata;
        if (start_ls) begin
            start_addr = sel_addr;
        end else begin
            start_addr = fetch_req ? fetch_pc : fb_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= mem_pkg::ST_IDLE;
            cnt          <= 3'd0;
            fb_valid     <= 1'b0;
            lsb_valid    <= 1'b0;
            ram_wr_q     <= 1'b0;
            fetch_ok     <= 1'b0;
            ls_ok        <= 1'b0;
            ls_was_store <= 1'b0;
        end else begin
            fetch_ok <= 1'b0;
            ls_ok    <= 1'b0;
            if (enable) begin
                if (drop_run) begin
                    state <= mem_pkg::ST_IDLE;
                end

                if (cap_f) begin
                    fb_valid <= 1'b1;
                end else if (start_f || fetch_drop) begin
                    fb_valid <= 1'b0;
                end

                if (cap_ls) begin
                    lsb_valid <= 1'b1;
                end else if (start_ls || drop_lsb) begin
                    lsb_valid <= 1'b0;
                end

                if (start_ls) begin
                    state    <= (sel_op == mem_pkg::OP_WRITE) ? mem_pkg::ST_STORE
                                                              : mem_pkg::ST_LOAD;
                    cnt      <= 3'd0;
                    ram_wr_q <= 1'b0;
                end else if (start_f) begin
                    state    <= mem_pkg::ST_FETCH;
                    cnt      <= 3'd0;
                    ram_wr_q <= 1'b0;
                end else if (step_rd || step_st) begin
                    if (at_end) begin
                        state    <= mem_pkg::ST_IDLE;
                        ram_wr_q <= 1'b0;
                        if (state == mem_pkg::ST_FETCH) begin
                            fetch_ok <= 1'b1;
                        end else begin
                            ls_ok        <= 1'b1;
                            ls_was_store <= step_st;
                        end
                    end else begin
                        cnt      <= cnt + 3'd1;
                        ram_wr_q <= step_st;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_f) begin
            fb_pc <= fetch_pc;
        end
        if (cap_ls) begin
            lsb_op    <= ls_op;
            lsb_size  <= ls_size;
            lsb_addr  <= ls_addr;
            lsb_wdata <= ls_wdata;
        end

        if (start_ls || start_f) begin
            rd_data <= '0;
            if (start_ls) begin
                run_len  <= sel_size;
                run_data <= sel_wdata;
            end else begin
                run_len <= 3'd4;
            end
            if (start_ls && sel_op == mem_pkg::OP_WRITE) begin
                run_addr <= start_addr;
            end else begin
                // first read address goes out with the start
                ram_addr_q <= start_addr;
                run_addr   <= start_addr + mem_pkg::addr_t'(1);
            end
        end else if (step_rd) begin
            // byte arrives one cycle after its address
            case (cnt)
                3'd1: rd_data[7:0]   <= ram_rdata;
                3'd2: rd_data[15:8]  <= ram_rdata;
                3'd3: rd_data[23:16] <= ram_rdata;
                3'd4: rd_data[31:24] <= ram_rdata;
                default: ;
            endcase
            if (!at_end) begin
                ram_addr_q <= run_addr;
                run_addr   <= run_addr + mem_pkg::addr_t'(1);
            end
        end else if (step_st && !at_end) begin
            ram_addr_q <= run_addr;
            ram_wdata  <= run_data[7:0];
            run_data   <= run_data >> 8;
            run_addr   <= run_addr + mem_pkg::addr_t'(1);
        end
    end

    // while frozen mid-read the RAM keeps reading the byte still owed
    assign ram_addr = (!enable && cnt != 3'd0
                       && (state == mem_pkg::ST_FETCH || state == mem_pkg::ST_LOAD))
                      ? ram_addr_q - mem_pkg::addr_t'(1) : ram_addr_q;

    // frozen while disabled
    assign ram_wr     = ram_wr_q && enable;
    assign fetch_inst = rd_data;
    assign ls_rdata   = rd_data;

endmodule

//--- verilog/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_WORD_W-1:0] word_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    // value is the number of bytes moved
    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd1,
        SIZE_HALF = 3'd2,
        SIZE_WORD = 3'd4
    } mem_size_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_LOAD  = 2'd2,
        ST_STORE = 2'd3
    } ctrl_state_e;

    typedef logic [`MEM_CNT_W-1:0] cnt_t;

endpackage

//--- verilog/mem_subsys.sv
`timescale 1ns/1ps
`include "mem_consts.svh"

module mem_subsys (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               fetch_req,
    input  logic               fetch_drop,
    input  mem_pkg::addr_t     fetch_pc,
    output logic               fetch_ok,
    output mem_pkg::word_t     fetch_inst,
    input  logic               ls_req,
    input  mem_pkg::mem_op_e   ls_op,
    input  mem_pkg::mem_size_e ls_size,
    input  mem_pkg::addr_t     ls_addr,
    input  mem_pkg::word_t     ls_wdata,
    output logic               ls_ok,
    output mem_pkg::word_t     ls_rdata
);

    logic                   enable;
    logic                   ls_was_store;
    mem_pkg::addr_t         ram_addr;
    logic                   ram_wr;
    logic [`MEM_BYTE_W-1:0] ram_wdata;
    logic [`MEM_BYTE_W-1:0] ram_rdata;

    mem_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .fetch_req    (fetch_req),
        .fetch_drop   (fetch_drop),
        .fetch_pc     (fetch_pc),
        .fetch_ok     (fetch_ok),
        .fetch_inst   (fetch_inst),
        .ls_req       (ls_req),
        .ls_op        (ls_op),
        .ls_size      (ls_size),
        .ls_addr      (ls_addr),
        .ls_wdata     (ls_wdata),
        .ls_ok        (ls_ok),
        .ls_was_store (ls_was_store),
        .ls_rdata     (ls_rdata),
        .ram_addr     (ram_addr),
        .ram_wr       (ram_wr),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    byte_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wr    (ram_wr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_cfg_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .fetch_ok     (fetch_ok),
        .ls_ok        (ls_ok),
        .ls_was_store (ls_was_store),
        .enable       (enable)
    );

endmodule
